/* vlane_alu_pkg.sv */
`default_nettype none

package vlane_alu_pkg;

   localparam int DATA_W = 32;              // element lane width
   localparam int PROD_W = 2 * DATA_W;      // full product width

   // opcodes 16..31 are illegal
   typedef enum logic [4:0] {
      OP_ADD   = 5'd0,
      OP_SUB   = 5'd1,
      OP_AND   = 5'd2,
      OP_OR    = 5'd3,
      OP_XOR   = 5'd4,
      OP_SLT   = 5'd5,
      OP_SLTU  = 5'd6,
      OP_SEQ   = 5'd7,
      OP_SNE   = 5'd8,
      OP_SLE   = 5'd9,
      OP_SLEU  = 5'd10,
      OP_SGT   = 5'd11,
      OP_SGTU  = 5'd12,
      OP_MUL   = 5'd13,
      OP_MULH  = 5'd14,
      OP_MULHU = 5'd15
   } alu_op_e;

   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2                         // encoding 3 is illegal
   } sew_e;

   // operands of these ops are sign extended from sew
   function automatic logic is_signed_op(input alu_op_e op);
      return op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLE, OP_SGT, OP_SEQ, OP_SNE,
                        OP_MUL, OP_MULH};
   endfunction

   function automatic logic is_compare_op(input alu_op_e op);
      return op inside {OP_SLT, OP_SLTU, OP_SEQ, OP_SNE, OP_SLE, OP_SLEU, OP_SGT,
                        OP_SGTU};
   endfunction

   function automatic logic is_mulh_op(input alu_op_e op);
      return op inside {OP_MULH, OP_MULHU};
   endfunction

   function automatic logic [5:0] sew_bits(input sew_e sew);
      case (sew)
         SEW_8:   return 6'd8;
         SEW_16:  return 6'd16;
         default: return 6'd32;
      endcase
   endfunction

   // widen the low sew bits of val to a full lane, signed when sgn is set
   function automatic logic [DATA_W-1:0] sew_extend(input logic [DATA_W-1:0] val,
                                                    input sew_e sew, input logic sgn);
      case (sew)
         SEW_8:   return {{(DATA_W-8){sgn & val[7]}}, val[7:0]};
         SEW_16:  return {{(DATA_W-16){sgn & val[15]}}, val[15:0]};
         default: return val;
      endcase
   endfunction

endpackage

`default_nettype wire

/* alu_pipe_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_ctrl (
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   alu_vld_i,
   input  wire vlane_alu_pkg::alu_op_e alu_op_i,
   input  wire vlane_alu_pkg::sew_e    sew_i,
   output logic                        vld_s1_o,
   output logic                        vld_s2_o,
   output logic                        alu_vld_o,
   output vlane_alu_pkg::alu_op_e      op_s1_o,
   output vlane_alu_pkg::alu_op_e      op_s2_o,
   output vlane_alu_pkg::sew_e         sew_s1_o,
   output vlane_alu_pkg::sew_e         sew_s2_o
);
   import vlane_alu_pkg::*;

   // valid chain with one bit per stage
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_s1_o  <= 1'b0;
         vld_s2_o  <= 1'b0;
         alu_vld_o <= 1'b0;
      end
      else
      begin
         vld_s1_o  <= alu_vld_i;            // operand regs load together with this
         vld_s2_o  <= vld_s1_o;             // compare and arith results ready
         alu_vld_o <= vld_s2_o;             // lines up with result_o
      end
   end

   // opcode and sew follow their element down the pipe
   always_ff @(posedge clk)
   begin
      op_s1_o  <= alu_op_i;
      sew_s1_o <= sew_i;
      op_s2_o  <= op_s1_o;
      sew_s2_o <= sew_s1_o;
   end

   // only defined opcodes and element widths may enter the lane
   a_legal_input: assert property (@(posedge clk) disable iff (!rstn)
      alu_vld_i |-> (alu_op_i <= OP_MULHU) && (sew_i <= SEW_32));

   // the strobe and the fields it qualifies arrive fully driven
   a_known_input: assert property (@(posedge clk) disable iff (!rstn)
      !$isunknown(alu_vld_i) && (!alu_vld_i || !$isunknown({alu_op_i, sew_i})));

endmodule

`default_nettype wire

/* alu_operand_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_operand_stage (
   input  wire logic                                clk,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    op1_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    op2_i,
   input  wire vlane_alu_pkg::alu_op_e              op_s1_i,
   input  wire vlane_alu_pkg::sew_e                 sew_s1_i,
   output logic      [vlane_alu_pkg::DATA_W-1:0]    ext_a_o,
   output logic      [vlane_alu_pkg::DATA_W-1:0]    ext_b_o
);
   import vlane_alu_pkg::*;

   logic [DATA_W-1:0] op1_q;                // raw operand a
   logic [DATA_W-1:0] op2_q;                // raw operand b
   logic              sext;                 // sign extend this element

   // free running, the valid chain tells later stages what to keep
   always_ff @(posedge clk)
   begin
      op1_q <= op1_i;
      op2_q <= op2_i;
   end

   assign sext = is_signed_op(op_s1_i);     // signed ops widen with the sew msb

   // only the low sew bits of each operand carry the element
   always_comb
   begin
      ext_a_o = sew_extend(op1_q, sew_s1_i, sext);
      ext_b_o = sew_extend(op2_q, sew_s1_i, sext);
   end

endmodule

`default_nettype wire

/* alu_compare_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_compare_unit (
   input  wire logic                                clk,
   input  wire logic                                vld_s1_i,
   input  wire vlane_alu_pkg::alu_op_e              op_s1_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    ext_a_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    ext_b_i,
   output logic                                     cmp_flag_o
);
   import vlane_alu_pkg::*;

   logic lt;                                // a below b in the op's order
   logic eq;                                // a equals b
   logic cmp_next;

   always_comb
   begin
      eq = (ext_a_i == ext_b_i);
      if (is_signed_op(op_s1_i))
         lt = ($signed(ext_a_i) < $signed(ext_b_i));
      else
         lt = (ext_a_i < ext_b_i);          // sltu, sleu, sgtu
      case (op_s1_i)
         OP_SLT, OP_SLTU: cmp_next = lt;
         OP_SLE, OP_SLEU: cmp_next = lt | eq;
         OP_SGT, OP_SGTU: cmp_next = ~(lt | eq);
         OP_SEQ:          cmp_next = eq;
         OP_SNE:          cmp_next = ~eq;
         default:         cmp_next = 1'b0;  // not a compare
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (vld_s1_i)
      begin
         cmp_flag_o <= cmp_next;
      end
   end

endmodule

`default_nettype wire

/* alu_arith_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_arith_unit (
   input  wire logic                                clk,
   input  wire logic                                vld_s1_i,
   input  wire vlane_alu_pkg::alu_op_e              op_s1_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    ext_a_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    ext_b_i,
   output logic      [vlane_alu_pkg::DATA_W-1:0]    alu_res_o,
   output logic      [vlane_alu_pkg::PROD_W-1:0]    prod_o
);
   import vlane_alu_pkg::*;

   logic [DATA_W-1:0] res_next;             // add/sub/logic result
   logic [PROD_W-1:0] a_wide;               // operand a at product width
   logic [PROD_W-1:0] b_wide;               // operand b at product width
   logic [PROD_W-1:0] prod_next;
   logic              mul_signed;           // mul and mulh, not mulhu

   always_comb
   begin
      case (op_s1_i)
         OP_ADD:  res_next = ext_a_i + ext_b_i;
         OP_SUB:  res_next = ext_a_i - ext_b_i;
         OP_AND:  res_next = ext_a_i & ext_b_i;
         OP_OR:   res_next = ext_a_i | ext_b_i;
         OP_XOR:  res_next = ext_a_i ^ ext_b_i;
         default: res_next = '0;            // compares and multiplies go elsewhere
      endcase
   end

   assign mul_signed = is_signed_op(op_s1_i);

   // widen to 64 bits so one unsigned multiply covers both signed cases
   always_comb
   begin
      if (mul_signed)
      begin
         a_wide = {{DATA_W{ext_a_i[DATA_W-1]}}, ext_a_i};
         b_wide = {{DATA_W{ext_b_i[DATA_W-1]}}, ext_b_i};
      end
      else
      begin
         a_wide = {{DATA_W{1'b0}}, ext_a_i};
         b_wide = {{DATA_W{1'b0}}, ext_b_i};
      end
      prod_next = a_wide * b_wide;          // low 64 bits are exact
   end

   // both results hold while no element is in stage 1
   always_ff @(posedge clk)
   begin
      if (vld_s1_i)
      begin
         alu_res_o <= res_next;
         prod_o    <= prod_next;
      end
   end

endmodule

`default_nettype wire

/* alu_result_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_result_stage (
   input  wire logic                                clk,
   input  wire logic                                vld_s2_i,
   input  wire vlane_alu_pkg::alu_op_e              op_s2_i,
   input  wire vlane_alu_pkg::sew_e                 sew_s2_i,
   input  wire logic                                cmp_flag_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    alu_res_i,
   input  wire logic [vlane_alu_pkg::PROD_W-1:0]    prod_i,
   output logic      [vlane_alu_pkg::DATA_W-1:0]    result_o
);
   import vlane_alu_pkg::*;

   logic [DATA_W-1:0] hi_half;              // product bits from sew upward
   logic [DATA_W-1:0] res_sel;

   // bits [2*sew-1:sew] land in the low sew bits and sew_extend trims the rest
   assign hi_half = DATA_W'(prod_i >> sew_bits(sew_s2_i));

   always_comb
   begin
      if (is_compare_op(op_s2_i))
         res_sel = {{(DATA_W-1){1'b0}}, cmp_flag_i};    // flag in bit 0 only
      else if (is_mulh_op(op_s2_i))
         res_sel = sew_extend(hi_half, sew_s2_i, is_signed_op(op_s2_i));
      else if (op_s2_i == OP_MUL)
         res_sel = prod_i[DATA_W-1:0];     // low half of the product
      else
         res_sel = alu_res_i;
   end

   // output holds its last value between elements
   always_ff @(posedge clk)
   begin
      if (vld_s2_i)
      begin
         result_o <= res_sel;
      end
   end

   // extended operands keep a product within 2*sew bits so trimming loses nothing
   a_mulh_fits: assert property (@(posedge clk)
      vld_s2_i && is_mulh_op(op_s2_i) |-> res_sel == hi_half);

endmodule

`default_nettype wire

/* vlane_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module vlane_alu (
   input  wire logic                                clk,
   input  wire logic                                rstn,
   input  wire logic                                alu_vld_i,
   input  wire vlane_alu_pkg::alu_op_e              alu_op_i,
   input  wire vlane_alu_pkg::sew_e                 sew_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    op1_i,
   input  wire logic [vlane_alu_pkg::DATA_W-1:0]    op2_i,
   output logic                                     alu_vld_o,
   output logic      [vlane_alu_pkg::DATA_W-1:0]    result_o
);
   import vlane_alu_pkg::*;

   logic              vld_s1;               // element in operand stage
   logic              vld_s2;               // element in result stage
   alu_op_e           op_s1;
   alu_op_e           op_s2;
   sew_e              sew_s1;
   sew_e              sew_s2;
   logic [DATA_W-1:0] ext_a;                // extended operands
   logic [DATA_W-1:0] ext_b;
   logic              cmp_flag;
   logic [DATA_W-1:0] alu_res;
   logic [PROD_W-1:0] prod;

   alu_pipe_ctrl u_pipe_ctrl (
      .clk       (clk),
      .rstn      (rstn),
      .alu_vld_i (alu_vld_i),
      .alu_op_i  (alu_op_i),
      .sew_i     (sew_i),
      .vld_s1_o  (vld_s1),
      .vld_s2_o  (vld_s2),
      .alu_vld_o (alu_vld_o),
      .op_s1_o   (op_s1),
      .op_s2_o   (op_s2),
      .sew_s1_o  (sew_s1),
      .sew_s2_o  (sew_s2)
   );

   alu_operand_stage u_operand_stage (
      .clk      (clk),
      .op1_i    (op1_i),
      .op2_i    (op2_i),
      .op_s1_i  (op_s1),
      .sew_s1_i (sew_s1),
      .ext_a_o  (ext_a),
      .ext_b_o  (ext_b)
   );

   alu_compare_unit u_compare_unit (
      .clk        (clk),
      .vld_s1_i   (vld_s1),
      .op_s1_i    (op_s1),
      .ext_a_i    (ext_a),
      .ext_b_i    (ext_b),
      .cmp_flag_o (cmp_flag)
   );

   alu_arith_unit u_arith_unit (
      .clk       (clk),
      .vld_s1_i  (vld_s1),
      .op_s1_i   (op_s1),
      .ext_a_i   (ext_a),
      .ext_b_i   (ext_b),
      .alu_res_o (alu_res),
      .prod_o    (prod)
   );

   alu_result_stage u_result_stage (
      .clk        (clk),
      .vld_s2_i   (vld_s2),
      .op_s2_i    (op_s2),
      .sew_s2_i   (sew_s2),
      .cmp_flag_i (cmp_flag),
      .alu_res_i  (alu_res),
      .prod_i     (prod),
      .result_o   (result_o)
   );

endmodule

`default_nettype wire

/* tb_alu_model.svh */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// 16 bit fibonacci lfsr, taps 16 14 13 11, new bit enters at the bottom
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// keep the low w bits of v and fill the rest with zeros or copies of bit w-1
function automatic logic [63:0] widen(input logic [63:0] v, input int w, input logic sgn);
   logic [63:0] mask;
   logic        msb;
   mask = (64'd1 << w) - 64'd1;
   msb  = |(v & (64'd1 << (w - 1)));
   if (sgn && msb)
      return v | ~mask;
   return v & mask;
endfunction

// expected lane result for one element
function automatic logic [31:0] model_result(input alu_op_e op, input sew_e sew,
                                             input logic [31:0] a, input logic [31:0] b);
   int          w;
   logic        sgn;
   logic        lt;
   logic [63:0] xa;
   logic [63:0] xb;
   logic [63:0] p;
   logic [63:0] hi;
   w   = (sew == SEW_8) ? 8 : (sew == SEW_16) ? 16 : 32;
   sgn = op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLE, OP_SGT, OP_SEQ, OP_SNE, OP_MUL, OP_MULH};
   xa  = widen({32'd0, a}, w, sgn);       // 64 bit wide so signed compare and product are exact
   xb  = widen({32'd0, b}, w, sgn);
   lt  = sgn ? ($signed(xa) < $signed(xb)) : (xa < xb);
   p   = xa * xb;
   hi  = widen(p >> w, w, sgn);            // bits [2*sew-1:sew] of the product
   case (op)
      OP_ADD:            return xa[31:0] + xb[31:0];
      OP_SUB:            return xa[31:0] - xb[31:0];
      OP_AND:            return xa[31:0] & xb[31:0];
      OP_OR:             return xa[31:0] | xb[31:0];
      OP_XOR:            return xa[31:0] ^ xb[31:0];
      OP_SLT, OP_SLTU:   return {31'd0, lt};
      OP_SLE, OP_SLEU:   return {31'd0, lt | (xa == xb)};
      OP_SGT, OP_SGTU:   return {31'd0, !lt && (xa != xb)};
      OP_SEQ:            return {31'd0, xa == xb};
      OP_SNE:            return {31'd0, xa != xb};
      OP_MUL:            return p[31:0];
      OP_MULH, OP_MULHU: return hi[31:0];
      default:           return 32'd0;
   endcase
endfunction

`endif

/* tb_vlane_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vlane_alu;
   import vlane_alu_pkg::*;

   `include "tb_alu_model.svh"

   logic              clk;
   logic              rstn;
   logic              alu_vld_i;
   alu_op_e           alu_op_i;
   sew_e              sew_i;
   logic [DATA_W-1:0] op1_i;
   logic [DATA_W-1:0] op2_i;
   logic              alu_vld_o;
   logic [DATA_W-1:0] result_o;

   logic [DATA_W-1:0] exp_q[$];             // expected results, oldest first
   logic [DATA_W-1:0] expected;
   logic [15:0]       lfsr_q;
   int                errors;
   int                test_base;            // error count at start of current test
   int                in_cnt;               // elements issued
   int                out_cnt;              // results seen
   int                n_pass;
   int                n_fail;

   vlane_alu UUT (
      .clk       (clk),
      .rstn      (rstn),
      .alu_vld_i (alu_vld_i),
      .alu_op_i  (alu_op_i),
      .sew_i     (sew_i),
      .op1_i     (op1_i),
      .op2_i     (op2_i),
      .alu_vld_o (alu_vld_o),
      .result_o  (result_o)
   );

   always #4 clk = ~clk;                    // 8 ns period

   a_reset_quiet: assert property (@(posedge clk) !rstn && ($past(rstn) == 1'b0) |-> !alu_vld_o)
   else
   begin
      $display("ERROR %0t: alu_vld_o high during reset", $time);
      errors++;
   end

   // every accepted element comes out exactly 3 edges later, nothing else does
   a_latency: assert property (@(posedge clk) disable iff (!rstn)
      alu_vld_o == $past(alu_vld_i, 3))
   else
   begin
      $display("ERROR %0t: alu_vld_o not 3 cycles after alu_vld_i", $time);
      errors++;
   end

   a_hold: assert property (@(posedge clk) disable iff (!rstn)
      !alu_vld_o |-> $stable(result_o))
   else
   begin
      $display("ERROR %0t: result_o changed while alu_vld_o low", $time);
      errors++;
   end

   // scoreboard, sampled on the falling edge where outputs are settled
   always @(negedge clk)
   begin
      if (rstn && alu_vld_o)
      begin
         out_cnt++;
         if (exp_q.size() == 0)
         begin
            $display("ERROR %0t: result with no element issued", $time);
            errors++;
         end
         else
         begin
            expected = exp_q.pop_front();
            a_result: assert (result_o == expected)
            else
            begin
               $display("ERROR %0t: result %h, expected %h", $time, result_o, expected);
               errors++;
            end
         end
      end
   end

   // n random bits, one lfsr step per bit
   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      repeat (n)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic draw_op(input int nbits, input int max, output alu_op_e op);
      logic [31:0] v;
      draw(nbits, v);
      while (v > max)
         draw(nbits, v);                    // out of range, try again
      op = alu_op_e'(v[4:0]);
   endtask

   task automatic draw_sew(output sew_e s);
      logic [31:0] v;
      draw(2, v);
      while (v[1:0] == 2'd3)
         draw(2, v);                        // encoding 3 is illegal
      s = sew_e'(v[1:0]);
   endtask

   task automatic issue(input alu_op_e op, input sew_e sew, input logic [31:0] a,
                        input logic [31:0] b);
      alu_vld_i = 1'b1;
      alu_op_i  = op;
      sew_i     = sew;
      op1_i     = a;
      op2_i     = b;
      exp_q.push_back(model_result(op, sew, a, b));
      in_cnt++;
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      alu_vld_i = 1'b0;
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   // wait for all issued elements to come out
   task automatic drain();
      int cyc;
      alu_vld_i = 1'b0;
      cyc       = 0;
      while (exp_q.size() != 0 && cyc < 20)
      begin
         @(posedge clk);
         #1;
         cyc++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout: %0d results never came out", exp_q.size());
         errors++;
         exp_q.delete();
      end
   endtask

   task automatic check_count(input int base_in, input int base_out);
      a_count: assert (in_cnt - base_in == out_cnt - base_out)
      else
      begin
         $display("ERROR %0t: %0d elements in, %0d results out", $time,
                  in_cnt - base_in, out_cnt - base_out);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      if (errors == test_base)
      begin
         $display("test %s ok", name);
         n_pass++;
      end
      else
      begin
         $display("test %s FAILED, %0d errors", name, errors - test_base);
         n_fail++;
      end
      test_base = errors;
   endtask

   initial
   begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] v;
      alu_op_e     op;
      sew_e        sew;
      int          base_in;
      int          base_out;
      $timeformat(-9, 1, " ns", 0);
      clk       = 1'b0;
      rstn      = 1'b0;
      alu_vld_i = 1'b0;
      alu_op_i  = OP_ADD;
      sew_i     = SEW_8;
      op1_i     = '0;
      op2_i     = '0;
      lfsr_q    = 16'd10393;
      errors    = 0;
      test_base = 0;
      in_cnt    = 0;
      out_cnt   = 0;
      n_pass    = 0;
      n_fail    = 0;
      repeat (16) @(posedge clk);
      #1;
      rstn = 1'b1;

      for (int i = 0; i < 8; i++)
      begin
         a_idle_quiet: assert (!alu_vld_o)
         else
         begin
            $display("ERROR %0t: alu_vld_o high while idle", $time);
            errors++;
         end
         idle(1);
      end
      end_test("reset_idle");

      for (int i = 0; i < 60; i++)
      begin
         draw_op(3, 4, op);                 // add through xor
         draw_sew(sew);
         draw(32, a);
         draw(32, b);
         issue(op, sew, a, b);
      end
      drain();
      end_test("add_sub_logic");

      for (int c = 5; c <= 12; c++)
      begin
         for (int i = 0; i < 12; i++)
         begin
            draw_sew(sew);
            draw(32, a);
            draw(32, b);
            if (i % 4 == 0)
               b = a;                       // equal operands
            else if (i % 4 == 1)
               a = a | 32'h8000_8080;       // msb set at every sew
            else if (i % 4 == 2)
            begin
               a = a | 32'h8000_8080;
               b = b | 32'h8000_8080;
            end
            issue(alu_op_e'(c[4:0]), sew, a, b);
         end
      end
      drain();
      end_test("compare");

      for (int m = 13; m <= 15; m++)
      begin
         for (int s = 0; s < 3; s++)
         begin
            for (int i = 0; i < 10; i++)
            begin
               draw(32, a);
               draw(32, b);
               if (i % 3 != 2)
                  a = a | 32'h8000_8080;    // negative when signed
               if (i % 3 == 1)
                  b = b | 32'h8000_8080;
               issue(alu_op_e'(m[4:0]), sew_e'(s[1:0]), a, b);
            end
         end
      end
      drain();
      end_test("multiply");

      base_in  = in_cnt;
      base_out = out_cnt;
      for (int i = 0; i < 50; i++)
      begin
         draw_op(5, 15, op);
         draw_sew(sew);
         draw(32, a);
         draw(32, b);
         issue(op, sew, a, b);              // valid high every cycle
      end
      drain();
      check_count(base_in, base_out);
      end_test("back_to_back");

      base_in  = in_cnt;
      base_out = out_cnt;
      for (int i = 0; i < 12; i++)
      begin
         draw_op(5, 15, op);
         draw_sew(sew);
         draw(32, a);
         draw(32, b);
         issue(op, sew, a, b);
         draw(2, v);
         idle(2 + int'(v[1:0]));            // 2 to 5 idle cycles
      end
      drain();
      check_count(base_in, base_out);
      end_test("isolated_pulses");

      $display("summary: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
      if (n_fail == 0 && errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* vlane_alu.f */
+incdir+.
vlane_alu_pkg.sv
alu_pipe_ctrl.sv
alu_operand_stage.sv
alu_compare_unit.sv
alu_arith_unit.sv
alu_result_stage.sv
vlane_alu.sv
tb_vlane_alu.sv

/* Makefile */
# Verilator build and run for the vlane_alu testbench
VERILATOR ?= verilator
TOP       ?= tb_vlane_alu
FILELIST  ?= vlane_alu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb_alu_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
